/* Makefile */
TOP = iq_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wall -Wno-fatal \
		-f iq_top.f --top-module $(TOP) -o V$(TOP)

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

/* include/iq_params.svh */
`ifndef IQ_PARAMS_SVH
`define IQ_PARAMS_SVH

// Queue geometry. Depth must be a power of two.
`define IQ_DEPTH      16
`define IQ_LANES      4
`define IQ_INS_WIDTH  4

// Datapath widths.
`define IQ_DATA_W     32
`define IQ_REG_W      5
`define IQ_ROB_W      6

`endif

/* iq_top.f */
+incdir+include
src/iq_pkg.sv
src/iq_buffer.sv
src/issue_select.sv
src/exec_lane.sv
src/writeback_merge.sv
src/iq_top.sv
tests/iq_properties.sv
tests/iq_tb.sv

/* src/exec_lane.sv */
`timescale 1ns/1ps

module exec_lane
  import iq_pkg::*;
(
  input  logic         clock,
  input  logic         reset_n,
  input  logic         issue_i,
  input  iq_entry_t    entry_i,
  output logic         res_valid_o,
  output lane_result_t result_o
);

  data_t value;

  // Operand B is the source register index itself.
  always_comb begin
    case (entry_i.op)
      OP_ADD:  value = entry_i.imm + data_t'(entry_i.src_a);
      OP_XOR:  value = entry_i.imm ^ data_t'(entry_i.src_a);
      OP_SHL:  value = entry_i.imm << entry_i.src_a[2:0];
      OP_PASS: value = entry_i.imm;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Result register.
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n)
      res_valid_o <= 1'b0;
    else
      res_valid_o <= issue_i;
  end

  always_ff @(posedge clock) begin
    if (issue_i) begin
      result_o.dest     <= entry_i.dest;
      result_o.value    <= value;
      result_o.rob_slot <= entry_i.rob_slot;  // Keeps program order tag.
    end
  end

endmodule

/* src/iq_buffer.sv */
`timescale 1ns/1ps

`include "iq_params.svh"

module iq_buffer
  import iq_pkg::*;
(
  input  logic                          clock,
  input  logic                          reset_n,

  input  logic                          ins_enable_i,
  input  lane_cnt_t                     ins_count_i,
  input  iq_entry_t [`IQ_INS_WIDTH-1:0] ins_group_i,

  input  logic                          ext_enable_i,
  input  lane_cnt_t                     ext_count_i,

  input  logic                          flush_i,

  output logic      [`IQ_LANES-1:0]     head_valid_o,
  output iq_entry_t [`IQ_LANES-1:0]     head_o,
  output logic                          full_o,
  output logic                          empty_o,
  output occ_t                          used_count_o
);

  localparam int PTR_W = $clog2(`IQ_DEPTH);

  typedef logic [PTR_W-1:0] ptr_t;

  iq_entry_t            mem [`IQ_DEPTH];
  logic [`IQ_DEPTH-1:0] valid;
  ptr_t                 ins_ptr;
  ptr_t                 ext_ptr;

  logic                 ins_ok;
  logic                 ext_ok;
  lane_cnt_t            ext_cnt;
  occ_t                 ins_num;
  occ_t                 ext_num;

  // Flush wins over a same-cycle insert.
  assign ins_ok = ins_enable_i & ~full_o & ~flush_i;
  assign ext_ok = ext_enable_i & ~empty_o;

  // Never extract more than the queue holds.
  assign ext_cnt = (occ_t'(ext_count_i) >= used_count_o - 1'b1) ?
                   lane_cnt_t'(used_count_o - 1'b1) : ext_count_i;

  assign ins_num = ins_ok ? occ_t'(ins_count_i) + 1'b1 : '0;
  assign ext_num = ext_ok ? occ_t'(ext_cnt) + 1'b1 : '0;

  ////////////////////////////////////////////////////////////
  // Storage and valid bits.
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (ins_ok) begin
      for (int i = 0; i < `IQ_INS_WIDTH; i++) begin
        if (i <= int'(ins_count_i))
          mem[ins_ptr + ptr_t'(i)] <= ins_group_i[i];
      end
    end
  end

  // Insert slots are always free, so they never overlap the extract run.
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      valid <= '0;
    end else if (flush_i) begin
      valid <= '0;
    end else begin
      for (int i = 0; i < `IQ_INS_WIDTH; i++) begin
        if (ins_ok && i <= int'(ins_count_i))
          valid[ins_ptr + ptr_t'(i)] <= 1'b1;
      end
      for (int i = 0; i < `IQ_LANES; i++) begin
        if (ext_ok && i <= int'(ext_cnt))
          valid[ext_ptr + ptr_t'(i)] <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Pointers and occupancy.
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n)
      ins_ptr <= '0;
    else if (flush_i)
      ins_ptr <= '0;
    else if (ins_ok)
      ins_ptr <= ins_ptr + ptr_t'(ins_count_i) + 1'b1;  // Wraps at depth.
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n)
      ext_ptr <= '0;
    else if (flush_i)
      ext_ptr <= '0;
    else if (ext_ok)
      ext_ptr <= ext_ptr + ptr_t'(ext_cnt) + 1'b1;
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n)
      used_count_o <= '0;
    else if (flush_i)
      used_count_o <= '0;
    else
      used_count_o <= used_count_o + ins_num - ext_num;
  end

  // Head window starting at the extract pointer.
  always_comb begin
    for (int i = 0; i < `IQ_LANES; i++) begin
      head_o[i]       = mem[ext_ptr + ptr_t'(i)];
      head_valid_o[i] = valid[ext_ptr + ptr_t'(i)];
    end
  end

  assign empty_o = (used_count_o == '0);
  assign full_o  = (used_count_o > occ_t'(`IQ_DEPTH - `IQ_INS_WIDTH));

endmodule

/* src/iq_pkg.sv */
package iq_pkg;

  `include "iq_params.svh"

  typedef logic [`IQ_DATA_W-1:0]        data_t;
  typedef logic [`IQ_REG_W-1:0]         reg_idx_t;
  typedef logic [`IQ_ROB_W-1:0]         rob_slot_t;
  typedef logic [1:0]                   op_t;
  typedef logic [$clog2(`IQ_LANES)-1:0] lane_cnt_t;  // Count minus one.
  typedef logic [$clog2(`IQ_DEPTH):0]   occ_t;       // 0 up to IQ_DEPTH.

  // Operation codes.
  localparam op_t OP_ADD  = 2'd0;  // imm + src_a.
  localparam op_t OP_XOR  = 2'd1;  // imm ^ src_a.
  localparam op_t OP_SHL  = 2'd2;  // imm << src_a[2:0].
  localparam op_t OP_PASS = 2'd3;  // imm.

  ////////////////////////////////////////////////////////////
  // Queue entry and lane result.
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    op_t       op;
    reg_idx_t  dest;
    reg_idx_t  src_a;
    data_t     imm;
    rob_slot_t rob_slot;
  } iq_entry_t;

  typedef struct packed {
    reg_idx_t  dest;
    data_t     value;
    rob_slot_t rob_slot;
  } lane_result_t;

endpackage

/* src/iq_top.sv */
`timescale 1ns/1ps

`include "iq_params.svh"

module iq_top
  import iq_pkg::*;
(
  input  logic                            clock,
  input  logic                            reset_n,

  input  logic                            ins_enable_i,
  input  lane_cnt_t                       ins_count_i,
  input  iq_entry_t    [`IQ_INS_WIDTH-1:0] ins_group_i,
  input  logic                            flush_i,

  output logic                            full_o,
  output logic                            empty_o,
  output occ_t                            used_count_o,

  output logic         [`IQ_LANES-1:0]    done_valid_o,
  output lane_result_t [`IQ_LANES-1:0]    done_o,
  output logic         [15:0]             retired_count_o
);

  logic         [`IQ_LANES-1:0] head_valid;
  iq_entry_t    [`IQ_LANES-1:0] head;
  logic                         ext_enable;
  lane_cnt_t                    ext_count;
  logic         [`IQ_LANES-1:0] lane_issue;
  logic         [`IQ_LANES-1:0] res_valid;
  lane_result_t [`IQ_LANES-1:0] lane_res;

  iq_buffer u_buffer (
    .clock        (clock),
    .reset_n      (reset_n),
    .ins_enable_i (ins_enable_i),
    .ins_count_i  (ins_count_i),
    .ins_group_i  (ins_group_i),
    .ext_enable_i (ext_enable),
    .ext_count_i  (ext_count),
    .flush_i      (flush_i),
    .head_valid_o (head_valid),
    .head_o       (head),
    .full_o       (full_o),
    .empty_o      (empty_o),
    .used_count_o (used_count_o)
  );

  issue_select u_select (
    .head_valid_i (head_valid),
    .head_i       (head),
    .ext_enable_o (ext_enable),
    .ext_count_o  (ext_count),
    .lane_issue_o (lane_issue)
  );

  ////////////////////////////////////////////////////////////
  // Execution lanes.
  ////////////////////////////////////////////////////////////

  for (genvar g = 0; g < `IQ_LANES; g++) begin : g_lane
    exec_lane u_lane (
      .clock       (clock),
      .reset_n     (reset_n),
      .issue_i     (lane_issue[g]),
      .entry_i     (head[g]),
      .res_valid_o (res_valid[g]),
      .result_o    (lane_res[g])
    );
  end

  writeback_merge u_writeback (
    .clock           (clock),
    .reset_n         (reset_n),
    .res_valid_i     (res_valid),
    .result_i        (lane_res),
    .done_valid_o    (done_valid_o),
    .done_o          (done_o),
    .retired_count_o (retired_count_o)
  );

endmodule

/* src/issue_select.sv */
`timescale 1ns/1ps

`include "iq_params.svh"

module issue_select
  import iq_pkg::*;
(
  input  logic      [`IQ_LANES-1:0] head_valid_i,
  input  iq_entry_t [`IQ_LANES-1:0] head_i,
  output logic                      ext_enable_o,
  output lane_cnt_t                 ext_count_o,
  output logic      [`IQ_LANES-1:0] lane_issue_o
);

  logic [`IQ_LANES-1:0] run;  // Prefix of issuable head entries.

  ////////////////////////////////////////////////////////////
  // Longest dependency-free run from the head.
  ////////////////////////////////////////////////////////////

  // An entry may join the run only if it does not read
  // the dest of any older entry already in the run.
  always_comb begin : find_run
    logic dep;
    run[0] = head_valid_i[0];
    for (int k = 1; k < `IQ_LANES; k++) begin
      dep = 1'b0;
      for (int j = 0; j < k; j++) begin
        if (head_i[k].src_a == head_i[j].dest)
          dep = 1'b1;
      end
      run[k] = run[k-1] & head_valid_i[k] & ~dep;
    end
  end

  // Highest set bit of the run gives the count minus one.
  always_comb begin
    ext_count_o = '0;
    for (int k = 1; k < `IQ_LANES; k++) begin
      if (run[k])
        ext_count_o = lane_cnt_t'(k);
    end
  end

  assign ext_enable_o = head_valid_i[0];
  assign lane_issue_o = run;  // Lanes 0 up to ext_count_o.

endmodule

/* src/writeback_merge.sv */
`timescale 1ns/1ps

`include "iq_params.svh"

module writeback_merge
  import iq_pkg::*;
(
  input  logic                         clock,
  input  logic                         reset_n,
  input  logic         [`IQ_LANES-1:0] res_valid_i,
  input  lane_result_t [`IQ_LANES-1:0] result_i,
  output logic         [`IQ_LANES-1:0] done_valid_o,
  output lane_result_t [`IQ_LANES-1:0] done_o,
  output logic         [15:0]          retired_count_o
);

  logic [$clog2(`IQ_LANES):0] valid_cnt;

  // Population count of the valid lanes.
  always_comb begin
    valid_cnt = '0;
    for (int i = 0; i < `IQ_LANES; i++)
      valid_cnt = valid_cnt + res_valid_i[i];
  end

  ////////////////////////////////////////////////////////////
  // Completion group, lane 0 is the oldest.
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n)
      done_valid_o <= '0;
    else
      done_valid_o <= res_valid_i;
  end

  always_ff @(posedge clock) begin
    done_o <= result_i;
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n)
      retired_count_o <= '0;
    else
      retired_count_o <= retired_count_o + 16'(valid_cnt);  // Running total.
  end

endmodule

/* tests/iq_properties.sv */
`timescale 1ns/1ps

`include "iq_params.svh"

module iq_properties
  import iq_pkg::*;
(
  input logic                         clock,
  input logic                         reset_n,
  input logic                         flush_i,
  input logic                         full_o,
  input logic                         empty_o,
  input occ_t                         used_count_o,
  input logic         [`IQ_LANES-1:0] done_valid_o,
  input logic         [15:0]          retired_count_o
);

  ////////////////////////////////////////////////////////////
  // Reset values.
  ////////////////////////////////////////////////////////////

  a_reset_state: assert property (@(posedge clock)
    !reset_n |-> (done_valid_o == '0 && empty_o && !full_o &&
                  used_count_o == '0 && retired_count_o == '0))
    else $error("outputs not at reset values while reset_n is low");

  // A done group is a run of lanes starting at lane 0.
  a_done_contiguous: assert property (@(posedge clock) disable iff (!reset_n)
    ((done_valid_o + 1'b1) & done_valid_o) == '0)
    else $error("done_valid_o is not a contiguous run from lane 0");

  a_flush_clears: assert property (@(posedge clock) disable iff (!reset_n)
    flush_i |=> (used_count_o == '0 && empty_o))
    else $error("queue not empty one edge after flush");

  a_occ_bound: assert property (@(posedge clock) disable iff (!reset_n)
    used_count_o <= occ_t'(`IQ_DEPTH))
    else $error("occupancy above queue depth");

endmodule

bind iq_top iq_properties u_props (.*);

/* tests/iq_tb.sv */
`timescale 1ns/1ps

`include "iq_params.svh"

module iq_tb
  import iq_pkg::*;
;

  localparam int NUM_GROUPS = 64;
  localparam int TIMEOUT    = NUM_GROUPS * 4 + 200;

  logic clock;
  logic reset_n;
  logic ins_enable_i;
  lane_cnt_t ins_count_i;
  iq_entry_t [`IQ_INS_WIDTH-1:0] ins_group_i;
  logic flush_i;
  logic full_o;
  logic empty_o;
  occ_t used_count_o;
  logic [`IQ_LANES-1:0] done_valid_o;
  lane_result_t [`IQ_LANES-1:0] done_o;
  logic [15:0] retired_count_o;

  integer    seed = 32'h86b3_11e3;
  iq_entry_t model[$];   // Accepted, not yet completed.
  int        hist_used[$];
  bit        hist_full[$];
  bit        hist_empty[$];
  int        hist_acc[$];
  int        errors = 0;
  int        checks = 0;
  int        tests = 0;
  int        acc_cnt = 0;
  int        cur_acc = 0;  // Accepted in the current drive cycle.
  int        total_done = 0;
  int        comp_base = 0;
  bit        occ_en = 0;
  rob_slot_t next_rob = '0;

  iq_top UUT (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  initial begin
    repeat (TIMEOUT) @(posedge clock);
    $display("timeout: queue did not drain in %0d cycles", TIMEOUT);
    $display("Test FAILED");
    $finish;
  end

  function automatic data_t expected_value(iq_entry_t e);
    case (e.op)
      2'd0:    return e.imm + data_t'(e.src_a);
      2'd1:    return e.imm ^ data_t'(e.src_a);
      2'd2:    return e.imm << e.src_a[2:0];
      default: return e.imm;
    endcase
  endfunction

  task automatic expect_equal(string name, longint exp, longint act);
    checks++;
    assert (exp == act) else begin
      $display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, act);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Completion monitor.
  ////////////////////////////////////////////////////////////

  always @(negedge clock) begin : monitor
    iq_entry_t exp;
    iq_entry_t grp[`IQ_LANES];
    int        occ;
    if (reset_n) begin
      for (int i = 0; i < `IQ_LANES; i++) begin
        if (done_valid_o[i]) begin
          checks++;
          assert (model.size() != 0) else begin
            $display("completion at %0t on lane %0d with no pending entry", $time, i);
            errors++;
          end
          if (model.size() != 0) begin
            exp = model.pop_front();
            grp[i] = exp;
            expect_equal("done_o.rob_slot", exp.rob_slot, done_o[i].rob_slot);
            expect_equal("done_o.dest", exp.dest, done_o[i].dest);
            expect_equal("done_o.value", expected_value(exp), done_o[i].value);
            for (int j = 0; j < i; j++) begin
              checks++;
              assert (grp[j].dest != exp.src_a) else begin
                $display("lane %0d reads dest of lane %0d in one group at %0t", i, j, $time);
                errors++;
              end
            end
          end
          total_done++;
        end
      end
      expect_equal("retired_count_o", total_done, retired_count_o);
      // Extraction shows up as completion one edge later.
      if (occ_en) begin
        hist_used.push_back(int'(used_count_o));
        hist_full.push_back(full_o);
        hist_empty.push_back(empty_o);
        hist_acc.push_back(acc_cnt - cur_acc);
        if (hist_used.size() > 1) begin
          occ = hist_acc.pop_front() - (total_done - comp_base);
          expect_equal("used_count_o", occ, hist_used.pop_front());
          expect_equal("full_o", occ > `IQ_DEPTH - `IQ_INS_WIDTH, hist_full.pop_front());
          expect_equal("empty_o", occ == 0, hist_empty.pop_front());
        end
      end
    end
  end

  task automatic idle(int n);
    repeat (n) begin
      @(posedge clock);
      #1;
      ins_enable_i = 1'b0;
      flush_i = 1'b0;
      cur_acc = 0;
    end
  endtask

  task automatic drive_group(int reg_mask, bit with_flush);
    int n;
    bit take;
    @(posedge clock);
    #1;
    n = $random(seed) & 3;
    take = !full_o && !with_flush;
    for (int i = 0; i < `IQ_INS_WIDTH; i++) begin
      ins_group_i[i].op = op_t'($random(seed));
      ins_group_i[i].dest = reg_idx_t'($random(seed) & reg_mask);
      ins_group_i[i].src_a = reg_idx_t'($random(seed) & reg_mask);
      ins_group_i[i].imm = data_t'($random(seed));
      ins_group_i[i].rob_slot = next_rob + rob_slot_t'(i);
    end
    ins_enable_i = 1'b1;
    ins_count_i = lane_cnt_t'(n);
    flush_i = with_flush;
    cur_acc = 0;
    if (take) begin
      for (int i = 0; i <= n; i++)
        model.push_back(ins_group_i[i]);
      next_rob = next_rob + rob_slot_t'(n + 1);
      acc_cnt = acc_cnt + n + 1;
      cur_acc = n + 1;
    end
  endtask

  task automatic drain();
    while (model.size() != 0)
      idle(1);
    idle(3);
  endtask

  task automatic finish_test(string name, int err_start);
    tests++;
    $display("test %0d %s done, %0d errors", tests, name, errors - err_start);
  endtask

  initial begin : stimulus
    int e0;
    reset_n = 1'b0;
    ins_enable_i = 1'b0;
    ins_count_i = '0;
    ins_group_i = '0;
    flush_i = 1'b0;
    repeat (8) @(posedge clock);
    #1;
    reset_n = 1'b1;
    occ_en = 1'b1;

    // Reset state.
    e0 = errors;
    @(negedge clock);
    expect_equal("done_valid_o", 0, done_valid_o);
    expect_equal("used_count_o", 0, used_count_o);
    expect_equal("empty_o", 1, empty_o);
    expect_equal("full_o", 0, full_o);
    expect_equal("retired_count_o", 0, retired_count_o);
    finish_test("reset state", e0);

    e0 = errors;
    for (int g = 0; g < 12; g++) begin
      drive_group(31, 1'b0);
      idle(1);
    end
    drain();
    finish_test("order and results", e0);

    // Few registers so that dependencies are frequent.
    e0 = errors;
    for (int g = 0; g < 12; g++)
      drive_group(3, 1'b0);
    drain();
    finish_test("dependency rule", e0);

    // One register serializes extraction, so the queue fills up.
    e0 = errors;
    for (int g = 0; g < 30; g++)
      drive_group(0, 1'b0);
    drain();
    finish_test("occupancy and back-pressure", e0);

    e0 = errors;
    for (int g = 0; g < 5; g++)
      drive_group(7, 1'b0);
    occ_en = 1'b0;
    drive_group(31, 1'b1);
    idle(1);
    @(negedge clock);
    expect_equal("used_count_o", 0, used_count_o);
    expect_equal("empty_o", 1, empty_o);
    idle(2);
    model.delete();  // Entries still queued at the flush are dropped.
    hist_used.delete();
    hist_full.delete();
    hist_empty.delete();
    hist_acc.delete();
    acc_cnt = 0;
    comp_base = total_done;
    occ_en = 1'b1;
    for (int g = 0; g < 4; g++)
      drive_group(31, 1'b0);
    drain();
    expect_equal("retired_count_o", total_done, retired_count_o);
    finish_test("flush", e0);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule
